/* source/vic_chip_pkg.sv */
package vic_chip_pkg;

    // video chip variants, selected by the strap pins at reset
    typedef enum logic [1:0] {
        chip_6567r56a = 2'd0,
        chip_6567r8   = 2'd1,
        chip_6569     = 2'd2
    } chip_t;

    // bus cycles per raster line, indexed by chip_t
    // code 3 is not a real chip and reuses the 6569 entry
    localparam logic [3:0][6:0] cycles_per_line = {7'd63, 7'd63, 7'd65, 7'd64};

    // raster lines per frame, indexed by chip_t
    localparam logic [3:0][8:0] lines_per_frame = {9'd312, 9'd312, 9'd263, 9'd262};

    // text display window
    localparam logic [8:0] first_fetch_line  = 9'd48;
    localparam logic [8:0] last_fetch_line   = 9'd247;
    localparam logic [6:0] first_fetch_cycle = 7'd15;
    // characters per text row
    localparam logic [5:0] text_columns      = 6'd40;

    // clocks of reset stretch before the synchronizer
    localparam logic [4:0] reset_hold = 5'd16;

endpackage

/* source/vic_bus_pkg.sv */
package vic_bus_pkg;

    // video memory bus, 16K bytes
    localparam int addr_w = 14;
    localparam int data_w = 8;

    // request slots each peer may have outstanding at the arbiter
    localparam logic [1:0] credits = 2'd2;

    // start of the character pointer matrix
    localparam logic [addr_w-1:0] screen_base = 14'h0400;

endpackage

/* source/clockgen.sv */
`timescale 1ns/1ps

module clockgen (
    input  logic                sys_clock,
    input  logic                internal_rst,
    input  vic_chip_pkg::chip_t chip_strap,
    output logic                core_rst,
    output vic_chip_pkg::chip_t chip,
    output logic                vic_slot
);
    import vic_chip_pkg::*;

    // stretch counter state
    logic [4:0] hold_cnt;
    logic       stretch;
    // two-flop synchronizer, bit 1 is the released core reset
    logic [1:0] rst_sync;

    // hold reset for reset_hold clocks once the outside reset drops
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            hold_cnt <= '0;
            stretch  <= 1'b1;
        end else if (stretch) begin
            hold_cnt <= hold_cnt + 5'd1;
            // last clock of the stretch
            if (hold_cnt == reset_hold - 5'd1) begin
                stretch <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            rst_sync <= 2'b11;
        end else begin
            rst_sync <= {rst_sync[0], stretch};
        end
    end

    assign core_rst = rst_sync[1];

    // strap is sampled for as long as the outside reset is held
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            chip <= chip_strap;
        end
    end

    // bus phase, high = video slot, low = cpu slot
    // keyed off the first sync stage so the first slot after core_rst is high
    always_ff @(posedge sys_clock) begin
        if (internal_rst || rst_sync[0]) begin
            vic_slot <= 1'b0;
        end else begin
            vic_slot <= ~vic_slot;
        end
    end

endmodule

/* source/raster_counter.sv */
`timescale 1ns/1ps

module raster_counter (
    input  logic                sys_clock,
    input  logic                core_rst,
    input  vic_chip_pkg::chip_t chip,
    input  logic                vic_slot,
    output logic [6:0]          raster_cycle,
    output logic [8:0]          raster_line,
    output logic                frame_start
);
    import vic_chip_pkg::*;

    // last cycle and last line for the latched chip
    logic [6:0] cycle_last;
    logic [8:0] line_last;

    assign cycle_last = cycles_per_line[chip] - 7'd1;
    assign line_last  = lines_per_frame[chip] - 9'd1;

    // one bus cycle per video slot, i.e. every second clock
    always_ff @(posedge sys_clock) begin
        if (core_rst) begin
            raster_cycle <= '0;
            raster_line  <= '0;
            frame_start  <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            if (vic_slot) begin
                if (raster_cycle == cycle_last) begin
                    raster_cycle <= '0;
                    if (raster_line == line_last) begin
                        raster_line <= '0;
                        // both counters back at the origin
                        frame_start <= 1'b1;
                    end else begin
                        raster_line <= raster_line + 9'd1;
                    end
                end else begin
                    raster_cycle <= raster_cycle + 7'd1;
                end
            end
        end
    end

endmodule

/* source/gfx_fetch.sv */
`timescale 1ns/1ps

module gfx_fetch (
    input  logic                           sys_clock,
    input  logic                           core_rst,
    input  logic                           vic_slot,
    input  logic [6:0]                     raster_cycle,
    input  logic [8:0]                     raster_line,
    output logic                           fetch_req,
    output logic [vic_bus_pkg::addr_w-1:0] fetch_addr,
    input  logic                           fetch_rvalid,
    input  logic [vic_bus_pkg::data_w-1:0] fetch_rdata,
    input  logic                           fetch_credit,
    output logic                           char_valid,
    output logic [vic_bus_pkg::data_w-1:0] char_code,
    output logic [5:0]                     char_col,
    output logic [4:0]                     char_row
);
    import vic_chip_pkg::*;
    import vic_bus_pkg::*;

    // offsets into the display window, these wrap when outside it
    logic [8:0]        line_off;
    logic [6:0]        cycle_off;
    logic              in_window;
    logic [4:0]        text_row;
    logic [5:0]        text_col;
    logic [addr_w-1:0] row_base;
    logic [1:0]        credit_cnt;
    logic              issue;
    // position tags for requests still at the arbiter
    logic [4:0]        tag_row [credits];
    logic [5:0]        tag_col [credits];
    logic              tag_wr;
    logic              tag_rd;

    assign line_off  = raster_line - first_fetch_line;
    assign cycle_off = raster_cycle - first_fetch_cycle;
    assign in_window = (line_off <= last_fetch_line - first_fetch_line) &&
                       (cycle_off < {1'b0, text_columns});

    // eight raster lines per text row
    assign text_row = line_off[7:3];
    assign text_col = cycle_off[5:0];
    assign row_base = addr_w'(text_row) * addr_w'(text_columns);

    // one read per video slot inside the window
    assign issue = vic_slot && in_window && (credit_cnt != 2'd0);

    always_ff @(posedge sys_clock) begin
        if (core_rst) begin
            fetch_req  <= 1'b0;
            credit_cnt <= credits;
            tag_wr     <= 1'b0;
            tag_rd     <= 1'b0;
        end else begin
            // request goes out in the cpu slot, is served in the next video slot
            fetch_req  <= issue;
            credit_cnt <= credit_cnt + 2'(fetch_credit) - 2'(issue);
            tag_wr     <= tag_wr ^ issue;
            tag_rd     <= tag_rd ^ fetch_rvalid;
        end
    end

    always_ff @(posedge sys_clock) begin
        if (issue) begin
            fetch_addr      <= screen_base + row_base + addr_w'(text_col);
            tag_row[tag_wr] <= text_row;
            tag_col[tag_wr] <= text_col;
        end
    end

    // responses come back in order, so the oldest tag labels the byte
    assign char_valid = fetch_rvalid;
    assign char_code  = fetch_rdata;
    assign char_row   = tag_row[tag_rd];
    assign char_col   = tag_col[tag_rd];

endmodule

/* source/cpu_port.sv */
`timescale 1ns/1ps

module cpu_port (
    input  logic                           sys_clock,
    input  logic                           core_rst,
    input  logic                           cpu_req,
    input  logic [vic_bus_pkg::addr_w-1:0] cpu_addr,
    input  logic                           cpu_we,
    input  logic [vic_bus_pkg::data_w-1:0] cpu_wdata,
    output logic                           cpu_ready,
    output logic                           cpu_rvalid,
    output logic [vic_bus_pkg::data_w-1:0] cpu_rdata,
    output logic                           port_req,
    output logic [vic_bus_pkg::addr_w-1:0] port_addr,
    output logic                           port_we,
    output logic [vic_bus_pkg::data_w-1:0] port_wdata,
    input  logic                           port_rvalid,
    input  logic [vic_bus_pkg::data_w-1:0] port_rdata,
    input  logic                           port_credit
);
    import vic_bus_pkg::*;

    logic [1:0] credit_cnt;
    // credits are loaded on the first clock after reset
    logic       primed;
    logic       take;
    // marks outstanding requests that are reads
    logic       rd_flag [credits];
    logic       flag_wr;
    logic       flag_rd;

    assign cpu_ready = (credit_cnt != 2'd0);
    assign take      = cpu_req && cpu_ready;

    always_ff @(posedge sys_clock) begin
        if (core_rst) begin
            credit_cnt <= 2'd0;
            primed     <= 1'b0;
            port_req   <= 1'b0;
            flag_wr    <= 1'b0;
            flag_rd    <= 1'b0;
        end else begin
            port_req <= take;
            flag_wr  <= flag_wr ^ take;
            // every response pops a flag, writes included
            flag_rd  <= flag_rd ^ port_rvalid;
            if (!primed) begin
                credit_cnt <= credits;
                primed     <= 1'b1;
            end else begin
                credit_cnt <= credit_cnt + 2'(port_credit) - 2'(take);
            end
        end
    end

    always_ff @(posedge sys_clock) begin
        if (take) begin
            port_addr        <= cpu_addr;
            port_we          <= cpu_we;
            port_wdata       <= cpu_wdata;
            rd_flag[flag_wr] <= !cpu_we;
        end
    end

    // write acks stay internal
    assign cpu_rvalid = port_rvalid && rd_flag[flag_rd];
    assign cpu_rdata  = port_rdata;

endmodule

/* source/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                           sys_clock,
    input  logic                           core_rst,
    input  logic                           vic_slot,
    input  logic                           fetch_req,
    input  logic [vic_bus_pkg::addr_w-1:0] fetch_addr,
    output logic                           fetch_rvalid,
    output logic [vic_bus_pkg::data_w-1:0] fetch_rdata,
    output logic                           fetch_credit,
    input  logic                           port_req,
    input  logic [vic_bus_pkg::addr_w-1:0] port_addr,
    input  logic                           port_we,
    input  logic [vic_bus_pkg::data_w-1:0] port_wdata,
    output logic                           port_rvalid,
    output logic [vic_bus_pkg::data_w-1:0] port_rdata,
    output logic                           port_credit,
    output logic                           ram_en,
    output logic                           ram_we,
    output logic [vic_bus_pkg::addr_w-1:0] ram_addr,
    output logic [vic_bus_pkg::data_w-1:0] ram_wdata,
    input  logic [vic_bus_pkg::data_w-1:0] ram_rdata
);
    import vic_bus_pkg::*;

    // fetch queue, reads only
    logic [addr_w-1:0] fq_addr [credits];
    logic              fq_wr;
    logic              fq_rd;
    logic [1:0]        fetch_count;
    // cpu queue
    logic [addr_w-1:0] cq_addr [credits];
    logic              cq_we [credits];
    logic [data_w-1:0] cq_wdata [credits];
    logic              cq_wr;
    logic              cq_rd;
    logic [1:0]        cpu_count;
    logic              fetch_grant;
    logic              cpu_grant;
    // owner of the access now in the RAM read stage
    logic              own_fetch;
    logic              own_cpu;

    // video slot favours fetch, cpu slot serves only the cpu
    assign fetch_grant = vic_slot && (fetch_count != 2'd0);
    assign cpu_grant   = !fetch_grant && (cpu_count != 2'd0);

    assign ram_en    = fetch_grant || cpu_grant;
    assign ram_we    = cpu_grant && cq_we[cq_rd];
    assign ram_addr  = fetch_grant ? fq_addr[fq_rd] : cq_addr[cq_rd];
    assign ram_wdata = cq_wdata[cq_rd];

    always_ff @(posedge sys_clock) begin
        if (core_rst) begin
            fq_wr       <= 1'b0;
            fq_rd       <= 1'b0;
            fetch_count <= 2'd0;
            cq_wr       <= 1'b0;
            cq_rd       <= 1'b0;
            cpu_count   <= 2'd0;
            own_fetch   <= 1'b0;
            own_cpu     <= 1'b0;
        end else begin
            fq_wr       <= fq_wr ^ fetch_req;
            fq_rd       <= fq_rd ^ fetch_grant;
            fetch_count <= fetch_count + 2'(fetch_req) - 2'(fetch_grant);
            cq_wr       <= cq_wr ^ port_req;
            cq_rd       <= cq_rd ^ cpu_grant;
            cpu_count   <= cpu_count + 2'(port_req) - 2'(cpu_grant);
            own_fetch   <= fetch_grant;
            own_cpu     <= cpu_grant;
        end
    end

    // credits bound the queues, so a push never finds them full
    always_ff @(posedge sys_clock) begin
        if (fetch_req) begin
            fq_addr[fq_wr] <= fetch_addr;
        end
        if (port_req) begin
            cq_addr[cq_wr]  <= port_addr;
            cq_we[cq_wr]    <= port_we;
            cq_wdata[cq_wr] <= port_wdata;
        end
    end

    // response and credit go back together one clock after the grant
    assign fetch_rvalid = own_fetch;
    assign fetch_credit = own_fetch;
    assign fetch_rdata  = ram_rdata;
    assign port_rvalid  = own_cpu;
    assign port_credit  = own_cpu;
    assign port_rdata   = ram_rdata;

endmodule

/* source/video_ram.sv */
`timescale 1ns/1ps

module video_ram (
    input  logic                           sys_clock,
    input  logic                           ram_en,
    input  logic                           ram_we,
    input  logic [vic_bus_pkg::addr_w-1:0] ram_addr,
    input  logic [vic_bus_pkg::data_w-1:0] ram_wdata,
    output logic [vic_bus_pkg::data_w-1:0] ram_rdata
);
    import vic_bus_pkg::*;

    // screen matrix and character memory share the array
    logic [data_w-1:0] mem [2**addr_w];

    always_ff @(posedge sys_clock) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_addr] <= ram_wdata;
            end else begin
                // read data is held until the next read
                ram_rdata <= mem[ram_addr];
            end
        end
    end

endmodule

/* source/vic_top.sv */
`timescale 1ns/1ps

module vic_top (
    input  logic                           sys_clock,
    input  logic                           internal_rst,
    input  vic_chip_pkg::chip_t            chip_strap,
    output vic_chip_pkg::chip_t            chip,
    input  logic                           cpu_req,
    input  logic [vic_bus_pkg::addr_w-1:0] cpu_addr,
    input  logic                           cpu_we,
    input  logic [vic_bus_pkg::data_w-1:0] cpu_wdata,
    output logic                           cpu_ready,
    output logic                           cpu_rvalid,
    output logic [vic_bus_pkg::data_w-1:0] cpu_rdata,
    output logic [6:0]                     raster_cycle,
    output logic [8:0]                     raster_line,
    output logic                           frame_start,
    output logic                           char_valid,
    output logic [vic_bus_pkg::data_w-1:0] char_code,
    output logic [5:0]                     char_col,
    output logic [4:0]                     char_row
);
    import vic_bus_pkg::*;

    logic              core_rst;
    logic              vic_slot;
    // fetch unit to arbiter
    logic              fetch_req;
    logic [addr_w-1:0] fetch_addr;
    logic              fetch_rvalid;
    logic [data_w-1:0] fetch_rdata;
    logic              fetch_credit;
    // cpu port to arbiter
    logic              port_req;
    logic [addr_w-1:0] port_addr;
    logic              port_we;
    logic [data_w-1:0] port_wdata;
    logic              port_rvalid;
    logic [data_w-1:0] port_rdata;
    logic              port_credit;
    // arbiter to RAM
    logic              ram_en;
    logic              ram_we;
    logic [addr_w-1:0] ram_addr;
    logic [data_w-1:0] ram_wdata;
    logic [data_w-1:0] ram_rdata;

    clockgen u_clockgen (
        .sys_clock(sys_clock), .internal_rst(internal_rst), .chip_strap(chip_strap),
        .core_rst(core_rst), .chip(chip), .vic_slot(vic_slot)
    );

    raster_counter u_raster (
        .sys_clock(sys_clock), .core_rst(core_rst), .chip(chip), .vic_slot(vic_slot),
        .raster_cycle(raster_cycle), .raster_line(raster_line), .frame_start(frame_start)
    );

    gfx_fetch u_fetch (
        .sys_clock(sys_clock), .core_rst(core_rst), .vic_slot(vic_slot),
        .raster_cycle(raster_cycle), .raster_line(raster_line),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_rvalid(fetch_rvalid),
        .fetch_rdata(fetch_rdata), .fetch_credit(fetch_credit),
        .char_valid(char_valid), .char_code(char_code),
        .char_col(char_col), .char_row(char_row)
    );

    cpu_port u_cpu_port (
        .sys_clock(sys_clock), .core_rst(core_rst),
        .cpu_req(cpu_req), .cpu_addr(cpu_addr), .cpu_we(cpu_we), .cpu_wdata(cpu_wdata),
        .cpu_ready(cpu_ready), .cpu_rvalid(cpu_rvalid), .cpu_rdata(cpu_rdata),
        .port_req(port_req), .port_addr(port_addr), .port_we(port_we),
        .port_wdata(port_wdata), .port_rvalid(port_rvalid), .port_rdata(port_rdata),
        .port_credit(port_credit)
    );

    bus_arbiter u_arbiter (
        .sys_clock(sys_clock), .core_rst(core_rst), .vic_slot(vic_slot),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_rvalid(fetch_rvalid),
        .fetch_rdata(fetch_rdata), .fetch_credit(fetch_credit),
        .port_req(port_req), .port_addr(port_addr), .port_we(port_we),
        .port_wdata(port_wdata), .port_rvalid(port_rvalid), .port_rdata(port_rdata),
        .port_credit(port_credit),
        .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

    video_ram u_ram (
        .sys_clock(sys_clock), .ram_en(ram_en), .ram_we(ram_we),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

endmodule

/* dv/vic_top_assert.sv */
`timescale 1ns/1ps

module vic_top_assert (
    input logic       sys_clock,
    input logic       core_rst,
    input logic       fetch_req,
    input logic       fetch_rvalid,
    input logic       fetch_credit,
    input logic [1:0] fetch_count,
    input logic       port_req,
    input logic       port_rvalid,
    input logic       port_credit,
    input logic [1:0] cpu_count
);
    import vic_bus_pkg::*;

    // requests taken by the arbiter and not yet answered
    logic [2:0] fetch_out;
    logic [2:0] cpu_out;

    always_ff @(posedge sys_clock) begin
        if (core_rst) begin
            fetch_out <= '0;
            cpu_out   <= '0;
        end else begin
            fetch_out <= fetch_out + 3'(fetch_req) - 3'(fetch_credit);
            cpu_out   <= cpu_out + 3'(port_req) - 3'(port_credit);
        end
    end

    // a peer only sends with a credit in hand, so its queue has room
    fetch_room: assert property (@(posedge sys_clock) disable iff (core_rst)
        fetch_req |-> fetch_count < credits)
        else $error("fetch request pushed into a full queue");

    cpu_room: assert property (@(posedge sys_clock) disable iff (core_rst)
        port_req |-> cpu_count < credits)
        else $error("cpu request pushed into a full queue");

    // credit goes back with the response to a request still open
    fetch_credit_resp: assert property (@(posedge sys_clock) disable iff (core_rst)
        fetch_credit |-> fetch_rvalid && fetch_out != 3'd0)
        else $error("fetch credit without a response to an open request");

    cpu_credit_resp: assert property (@(posedge sys_clock) disable iff (core_rst)
        port_credit |-> port_rvalid && cpu_out != 3'd0)
        else $error("cpu credit without a response to an open request");

    // queued in the cpu slot, granted in the next video slot, data one clock later
    fetch_latency: assert property (@(posedge sys_clock) disable iff (core_rst)
        $past(fetch_req, 2) |-> fetch_rvalid)
        else $error("fetch response not two clocks after its request");

endmodule

bind bus_arbiter vic_top_assert u_credit_assert (
    .sys_clock(sys_clock), .core_rst(core_rst),
    .fetch_req(fetch_req), .fetch_rvalid(fetch_rvalid), .fetch_credit(fetch_credit),
    .fetch_count(fetch_count),
    .port_req(port_req), .port_rvalid(port_rvalid), .port_credit(port_credit),
    .cpu_count(cpu_count)
);

/* dv/tb_vic_top.sv */
`timescale 1ns/1ps

module tb_vic_top;
    import vic_chip_pkg::*;
    import vic_bus_pkg::*;

    // longest frame is about 39k clocks
    localparam int frame_wait = 100000;
    localparam int short_wait = 200;

    logic              sys_clock;
    logic              internal_rst;
    chip_t             chip_strap;
    chip_t             chip;
    logic              cpu_req;
    logic [addr_w-1:0] cpu_addr;
    logic              cpu_we;
    logic [data_w-1:0] cpu_wdata;
    logic              cpu_ready;
    logic              cpu_rvalid;
    logic [data_w-1:0] cpu_rdata;
    logic [6:0]        raster_cycle;
    logic [8:0]        raster_line;
    logic              frame_start;
    logic              char_valid;
    logic [data_w-1:0] char_code;
    logic [5:0]        char_col;
    logic [4:0]        char_row;

    // mirror of every cpu write
    logic [data_w-1:0] model [2**addr_w];
    logic [data_w-1:0] exp_rd [$];
    int unsigned       line_count [512] = '{default: 0};
    logic              char_check;
    // text position the next code on this line should carry
    logic [4:0]        exp_row;
    logic [5:0]        exp_col;
    int                stall_clocks;
    int                clock_count = 0;
    string             test_name;

    vic_top dut (.*);

    initial sys_clock = 1'b0;
    always #5 sys_clock = ~sys_clock;

    always @(posedge sys_clock) clock_count <= clock_count + 1;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s, %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // screen matrix is row major, forty codes per text row
    function automatic logic [data_w-1:0] expected_char(input logic [4:0] row,
                                                        input logic [5:0] col);
        int index;
        index = int'(screen_base) + int'(row) * int'(text_columns) + int'(col);
        return model[addr_w'(index)];
    endfunction

    // read data, checked in issue order
    always @(negedge sys_clock) begin
        if (cpu_rvalid) begin
            if (exp_rd.size() == 0) begin
                report_failure("cpu read data arrived with no read outstanding");
            end else begin
                compare("cpu read data", 32'(exp_rd.pop_front()), 32'(cpu_rdata));
            end
        end
    end

    // character codes against the model, columns arrive in order along each line
    always @(negedge sys_clock) begin
        if (char_valid && char_check) begin
            exp_row = 5'((raster_line - first_fetch_line) >> 3);
            exp_col = 6'(line_count[raster_line]);
            compare("char row", 32'(exp_row), 32'(char_row));
            compare("char col", 32'(exp_col), 32'(char_col));
            compare("char code", 32'(expected_char(exp_row, exp_col)), 32'(char_code));
            line_count[raster_line] = line_count[raster_line] + 1;
        end
    end

    task automatic apply_reset(input chip_t strap);
        int low_clocks;
        low_clocks = 0;
        chip_strap = strap;
        internal_rst = 1'b1;
        repeat (2) @(posedge sys_clock);
        #1;
        internal_rst = 1'b0;
        @(posedge sys_clock);
        #1;
        while (!cpu_ready) begin
            low_clocks = low_clocks + 1;
            if (low_clocks > short_wait) report_failure("cpu_ready never rose after reset");
            @(posedge sys_clock);
            #1;
        end
        // stretch plus two synchronizer stages
        compare("cpu_ready low clocks", 32'(reset_hold) + 2, 32'(low_clocks));
        compare("chip", 32'(strap), 32'(chip));
        compare("frame_start after reset", 0, 32'(frame_start));
        compare("char_valid after reset", 0, 32'(char_valid));
        compare("cpu_rvalid after reset", 0, 32'(cpu_rvalid));
    endtask

    // called just after a rising edge, returns just after the accepting edge
    task automatic issue_cpu_access(input logic we, input logic [addr_w-1:0] addr,
                                    input logic [data_w-1:0] data);
        int guard;
        guard = 0;
        cpu_req = 1'b1;
        cpu_we = we;
        cpu_addr = addr;
        cpu_wdata = data;
        while (!cpu_ready) begin
            stall_clocks = stall_clocks + 1;
            guard = guard + 1;
            if (guard > short_wait) report_failure("cpu_ready stayed low, request not taken");
            @(posedge sys_clock);
            #1;
        end
        if (we) begin
            model[addr] = data;
        end else begin
            exp_rd.push_back(model[addr]);
        end
        @(posedge sys_clock);
        #1;
    endtask

    task automatic release_cpu_bus();
        cpu_req = 1'b0;
        cpu_we = 1'b0;
    endtask

    task automatic wait_reads_drained();
        int guard;
        guard = 0;
        while (exp_rd.size() != 0) begin
            guard = guard + 1;
            if (guard > short_wait) report_failure("cpu reads were not returned");
            @(posedge sys_clock);
            #1;
        end
    endtask

    task automatic wait_frame_start();
        int guard;
        guard = 0;
        @(negedge sys_clock);
        while (!frame_start) begin
            guard = guard + 1;
            if (guard > frame_wait) report_failure("no frame_start pulse within the timeout");
            @(negedge sys_clock);
        end
    endtask

    task automatic measure_frame_gap(input chip_t strap);
        int start;
        int guard;
        int expected;
        expected = 2 * int'(cycles_per_line[strap]) * int'(lines_per_frame[strap]);
        guard = 0;
        wait_frame_start();
        start = clock_count;
        // frame_start marks both counters back at zero
        compare("raster cycle at frame origin", 0, 32'(raster_cycle));
        compare("raster line at frame origin", 0, 32'(raster_line));
        @(negedge sys_clock);
        while (!frame_start) begin
            compare("raster cycle below line length", 1,
                    32'(raster_cycle < cycles_per_line[strap]));
            compare("raster line below frame height", 1,
                    32'(raster_line < lines_per_frame[strap]));
            guard = guard + 1;
            if (guard > frame_wait) report_failure("second frame_start pulse did not arrive");
            @(negedge sys_clock);
        end
        compare("frame_start spacing", 32'(expected), 32'(clock_count - start));
        @(posedge sys_clock);
        #1;
    endtask

    initial begin
        logic [addr_w-1:0] addrs [16];
        int cells;
        int guard;
        int expected;
        void'($urandom(5));
        cpu_req = 1'b0;
        cpu_addr = '0;
        cpu_we = 1'b0;
        cpu_wdata = '0;
        chip_strap = chip_6569;
        internal_rst = 1'b1;
        char_check = 1'b0;
        stall_clocks = 0;
        cells = int'((last_fetch_line - first_fetch_line + 1) >> 3) * int'(text_columns);

        test_name = "reset and chip";
        apply_reset(chip_6569);

        test_name = "cpu memory access";
        for (int i = 0; i < 16; i++) begin
            addrs[i] = screen_base + addr_w'($urandom % cells);
            issue_cpu_access(1'b1, addrs[i], data_w'($urandom));
        end
        for (int i = 0; i < 16; i++) begin
            issue_cpu_access(1'b0, addrs[i], '0);
        end
        release_cpu_bus();
        wait_reads_drained();

        test_name = "character fetch";
        for (int i = 0; i < cells; i++) begin
            issue_cpu_access(1'b1, screen_base + addr_w'(i), data_w'($urandom));
        end
        release_cpu_bus();
        wait_frame_start();
        char_check = 1'b1;
        wait_frame_start();
        char_check = 1'b0;
        for (int l = 0; l < 512; l++) begin
            expected = (l >= int'(first_fetch_line) && l <= int'(last_fetch_line)) ?
                       int'(text_columns) : 0;
            compare("codes per raster line", 32'(expected), 32'(line_count[l]));
        end

        test_name = "back-pressure";
        guard = 0;
        @(posedge sys_clock);
        #1;
        // start the burst where the fetch unit owns every video slot
        while (!(raster_line == first_fetch_line + 9'd8 && raster_cycle == first_fetch_cycle)) begin
            guard = guard + 1;
            if (guard > frame_wait) report_failure("fetch line never reached for the burst");
            @(posedge sys_clock);
            #1;
        end
        stall_clocks = 0;
        for (int i = 0; i < 8; i++) begin
            issue_cpu_access(1'b0, screen_base + addr_w'($urandom % cells), '0);
        end
        release_cpu_bus();
        compare("cpu_ready low during burst", 1, 32'(stall_clocks != 0));
        wait_reads_drained();

        test_name = "raster geometry";
        apply_reset(chip_6567r56a);
        measure_frame_gap(chip_6567r56a);
        apply_reset(chip_6567r8);
        measure_frame_gap(chip_6567r8);
        apply_reset(chip_6569);
        measure_frame_gap(chip_6569);

        $display("all tests passed");
        $finish;
    end

endmodule

/* compile.f */
source/vic_chip_pkg.sv
source/vic_bus_pkg.sv
source/clockgen.sv
source/raster_counter.sv
source/gfx_fetch.sv
source/cpu_port.sv
source/bus_arbiter.sv
source/video_ram.sv
source/vic_top.sv
dv/vic_top_assert.sv
dv/tb_vic_top.sv

/* Makefile */
# Verilator build and run of the vic_top testbench

SIM  = obj_dir/Vtb_vic_top
SRCS = $(wildcard source/*.sv) $(wildcard dv/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) compile.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_vic_top -f compile.f

# the log decides pass or fail
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
